//--- ahb_pkg.sv
package ahb_pkg;

        // ------------------------------
        // Bus widths
        // ------------------------------
        typedef logic [31:0] addr_t;    // Byte address
        typedef logic [31:0] data_t;    // Read and write data
        typedef logic [2:0]  hsize_t;   // HSIZE code

        // Size codes seen by the byte-lane logic
        localparam hsize_t HSIZE_BYTE = 3'b000;
        localparam hsize_t HSIZE_HALF = 3'b001;
        localparam hsize_t HSIZE_WORD = 3'b010;

        // ------------------------------
        // Transfer type
        // ------------------------------
        // Only NONSEQ and SEQ start a data phase
        typedef enum logic [1:0] {
                IDLE   = 2'b00,         // No transfer
                BUSY   = 2'b01,         // Master stall inside a burst
                NONSEQ = 2'b10,         // Single or first beat
                SEQ    = 2'b11          // Following beats
        } htrans_e;

endpackage

//--- periph_pkg.sv
package periph_pkg;

        // ------------------------------
        // Memory map
        // ------------------------------
        // Bits 31:28 pick the region, bits 15:12 the peripheral page
        localparam ahb_pkg::addr_t RAM_BASE  = 32'h0000_0000;
        localparam ahb_pkg::addr_t UART_BASE = 32'h4000_0000;
        localparam ahb_pkg::addr_t SPI_BASE  = 32'h4000_1000;

        typedef enum logic [1:0] {
                RAM, UART, SPI,
                NONE                    // Default slave
        } slave_idx_e;

        // Register offsets inside a peripheral page
        localparam logic [3:0] REG_DATA   = 4'h0;
        localparam logic [3:0] REG_STATUS = 4'h4;

        // ------------------------------
        // Peripheral data and FSMs
        // ------------------------------
        typedef logic [7:0]  byte_t;            // UART character
        typedef logic [23:0] spi_word_t;        // Tuner frame

        typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} uart_tx_state_e;
        typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} uart_rx_state_e;
        typedef enum logic {SPI_IDLE, SPI_SHIFT} spi_state_e;

endpackage

//--- ahb_slave_if.sv
interface ahb_slave_if;
        import ahb_pkg::*;

        // Data-phase view of one slave
        logic   sel;            // One-hot across slaves
        addr_t  addr;           // Captured in address phase
        logic   write;
        hsize_t size;
        data_t  wdata;          // Straight from hwdata
        data_t  rdata;

        modport decoder (
                output sel,
                output addr,
                output write,
                output size,
                output wdata,
                input  rdata
        );

        modport slave (
                input  sel,
                input  addr,
                input  write,
                input  size,
                input  wdata,
                output rdata
        );

endinterface

//--- ahb_decoder.sv
module ahb_decoder (
        input  logic             clk,
        input  logic             RSTn,
        input  ahb_pkg::addr_t   haddr,
        input  ahb_pkg::htrans_e htrans,
        input  ahb_pkg::hsize_t  hsize,
        input  logic             hwrite,
        input  ahb_pkg::data_t   hwdata,
        output ahb_pkg::data_t   hrdata,
        ahb_slave_if.decoder     ram_bus,
        ahb_slave_if.decoder     uart_bus,
        ahb_slave_if.decoder     spi_bus
);
        import ahb_pkg::*;
        import periph_pkg::*;

        logic       active;     // NONSEQ or SEQ
        slave_idx_e map_idx;    // Address-phase decode
        slave_idx_e dp_idx;     // Slave owning the data phase
        addr_t      dp_addr;
        logic       dp_write;
        hsize_t     dp_size;

        assign active = (htrans == NONSEQ) || (htrans == SEQ);

        // ------------------------------
        // Address decode
        // ------------------------------
        always_comb begin
                if (haddr[31:28] == RAM_BASE[31:28])
                        map_idx = RAM;
                else if (haddr[31:28] == UART_BASE[31:28] && haddr[15:12] == UART_BASE[15:12])
                        map_idx = UART;
                else if (haddr[31:28] == SPI_BASE[31:28] && haddr[15:12] == SPI_BASE[15:12])
                        map_idx = SPI;
                else
                        map_idx = NONE;         // Unmapped, reads 0
        end

        // Idle cycles park on the default slave
        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn)
                        dp_idx <= NONE;
                else
                        dp_idx <= active ? map_idx : NONE;
        end

        always_ff @(posedge clk) begin
                if (active) begin
                        dp_addr  <= haddr;
                        dp_write <= hwrite;
                        dp_size  <= hsize;
                end
        end

        // ------------------------------
        // Data phase fan-out
        // ------------------------------
        assign ram_bus.sel    = (dp_idx == RAM);
        assign uart_bus.sel   = (dp_idx == UART);
        assign spi_bus.sel    = (dp_idx == SPI);
        assign ram_bus.addr   = dp_addr;
        assign uart_bus.addr  = dp_addr;
        assign spi_bus.addr   = dp_addr;
        assign ram_bus.write  = dp_write;
        assign uart_bus.write = dp_write;
        assign spi_bus.write  = dp_write;
        assign ram_bus.size   = dp_size;
        assign uart_bus.size  = dp_size;
        assign spi_bus.size   = dp_size;
        assign ram_bus.wdata  = hwdata;         // Write data lags address by one cycle
        assign uart_bus.wdata = hwdata;
        assign spi_bus.wdata  = hwdata;

        // Read return mux
        always_comb begin
                case (dp_idx)
                        RAM:     hrdata = ram_bus.rdata;
                        UART:    hrdata = uart_bus.rdata;
                        SPI:     hrdata = spi_bus.rdata;
                        default: hrdata = '0;
                endcase
        end

endmodule

//--- ahb_ram.sv
module ahb_ram #(
        parameter int RAM_ADDR_WIDTH = 12
) (
        input  logic       clk,
        ahb_slave_if.slave bus
);
        import ahb_pkg::*;

        data_t                     mem [2**RAM_ADDR_WIDTH];
        logic [RAM_ADDR_WIDTH-1:0] word_addr;
        logic [3:0]                lane_en;

        // Word index, byte offset dropped
        assign word_addr = bus.addr[RAM_ADDR_WIDTH+1:2];

        // ------------------------------
        // Byte lanes
        // ------------------------------
        always_comb begin
                case (bus.size)
                        HSIZE_BYTE: lane_en = 4'b0001 << bus.addr[1:0];
                        HSIZE_HALF: lane_en = bus.addr[1] ? 4'b1100 : 4'b0011;
                        HSIZE_WORD: lane_en = 4'b1111;
                        default:    lane_en = 4'b1111;     // Wider sizes treated as word
                endcase
        end

        // Write lands as the data phase ends
        always_ff @(posedge clk) begin
                if (bus.sel && bus.write) begin
                        for (int i = 0; i < 4; i++) begin
                                if (lane_en[i])
                                        mem[word_addr][8*i +: 8] <= bus.wdata[8*i +: 8];
                        end
                end
        end

        // Async read on the registered address
        assign bus.rdata = mem[word_addr];

endmodule

//--- ahb_uart.sv
module ahb_uart #(
        parameter int CLKS_PER_BIT = 434
) (
        input  logic       clk,
        input  logic       RSTn,
        ahb_slave_if.slave bus,
        input  logic       rxd,
        output logic       txd,
        output logic       rx_irq
);
        import ahb_pkg::*;
        import periph_pkg::*;

        localparam int CW = $clog2(CLKS_PER_BIT + 1);

        logic           is_data;
        logic           tx_load;
        logic           tx_busy;
        logic           rd_data;
        uart_tx_state_e tx_state;
        logic [CW-1:0]  tx_cnt;
        logic [2:0]     tx_bit;
        byte_t          tx_shift;
        uart_rx_state_e rx_state;
        logic [CW-1:0]  rx_cnt;
        logic [2:0]     rx_bit;
        byte_t          rx_shift;
        byte_t          rx_data;
        logic           rx_valid;
        logic           rx_meta, rx_sync, rx_prev;

        assign is_data = (bus.addr[3:0] == REG_DATA);
        assign tx_busy = (tx_state != TX_IDLE);
        assign tx_load = bus.sel && bus.write && is_data && !tx_busy;  // Busy writes dropped
        assign rd_data = bus.sel && !bus.write && is_data;

        // ------------------------------
        // Transmitter
        // ------------------------------
        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        tx_state <= TX_IDLE;
                        tx_cnt   <= '0;
                        tx_bit   <= '0;
                        tx_shift <= '0;
                        txd      <= 1'b1;       // Line idles high
                end else begin
                        if (tx_state == TX_IDLE || tx_cnt == CW'(CLKS_PER_BIT - 1))
                                tx_cnt <= '0;
                        else
                                tx_cnt <= tx_cnt + 1'b1;
                        case (tx_state)
                                TX_IDLE: if (tx_load) begin
                                        tx_shift <= bus.wdata[7:0];
                                        txd      <= 1'b0;       // Start bit
                                        tx_state <= TX_START;
                                end
                                TX_START: if (tx_cnt == CW'(CLKS_PER_BIT - 1)) begin
                                        txd      <= tx_shift[0];
                                        tx_shift <= tx_shift >> 1;
                                        tx_bit   <= '0;
                                        tx_state <= TX_DATA;
                                end
                                TX_DATA: if (tx_cnt == CW'(CLKS_PER_BIT - 1)) begin
                                        if (tx_bit == 3'd7) begin
                                                txd      <= 1'b1;       // Stop bit
                                                tx_state <= TX_STOP;
                                        end else begin
                                                txd      <= tx_shift[0];  // LSB first
                                                tx_shift <= tx_shift >> 1;
                                                tx_bit   <= tx_bit + 1'b1;
                                        end
                                end
                                TX_STOP: if (tx_cnt == CW'(CLKS_PER_BIT - 1))
                                        tx_state <= TX_IDLE;
                                default: tx_state <= TX_IDLE;
                        endcase
                end
        end

        // ------------------------------
        // Receiver
        // ------------------------------
        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        rx_meta  <= 1'b1;
                        rx_sync  <= 1'b1;
                        rx_prev  <= 1'b1;
                        rx_state <= RX_IDLE;
                        rx_cnt   <= '0;
                        rx_bit   <= '0;
                        rx_shift <= '0;
                        rx_data  <= '0;
                        rx_valid <= 1'b0;
                        rx_irq   <= 1'b0;
                end else begin
                        rx_meta <= rxd;                 // Two-flop synchronizer
                        rx_sync <= rx_meta;
                        rx_prev <= rx_sync;
                        rx_irq  <= 1'b0;
                        rx_cnt  <= rx_cnt + 1'b1;
                        if (rd_data)
                                rx_valid <= 1'b0;       // Cleared by data read
                        case (rx_state)
                                RX_IDLE: begin
                                        rx_cnt <= '0;
                                        if (rx_prev && !rx_sync)
                                                rx_state <= RX_START;
                                end
                                RX_START: if (rx_cnt == CW'(CLKS_PER_BIT / 2 - 1)) begin
                                        rx_cnt   <= '0;
                                        rx_bit   <= '0;
                                        // Still low at mid-bit, otherwise a glitch
                                        rx_state <= rx_sync ? RX_IDLE : RX_DATA;
                                end
                                RX_DATA: if (rx_cnt == CW'(CLKS_PER_BIT - 1)) begin
                                        rx_cnt   <= '0;
                                        rx_shift <= {rx_sync, rx_shift[7:1]};
                                        rx_bit   <= rx_bit + 1'b1;
                                        if (rx_bit == 3'd7)
                                                rx_state <= RX_STOP;
                                end
                                RX_STOP: if (rx_cnt == CW'(CLKS_PER_BIT - 1)) begin
                                        rx_state <= RX_IDLE;
                                        if (rx_sync) begin      // Framing check
                                                rx_data  <= rx_shift;
                                                rx_valid <= 1'b1;
                                                rx_irq   <= 1'b1;
                                        end
                                end
                                default: rx_state <= RX_IDLE;
                        endcase
                end
        end

        // Status is {rx valid, tx busy}
        assign bus.rdata = (bus.addr[3:0] == REG_STATUS) ? data_t'({rx_valid, tx_busy})
                                                         : data_t'(rx_data);

endmodule

//--- ahb_spi.sv
module ahb_spi #(
        parameter int SPI_HALF_PERIOD = 4
) (
        input  logic       clk,
        input  logic       RSTn,
        ahb_slave_if.slave bus,
        output logic       sclk,
        output logic       sdata,
        output logic       cs,
        output logic       done_irq
);
        import ahb_pkg::*;
        import periph_pkg::*;

        localparam int HW = $clog2(SPI_HALF_PERIOD + 1);

        spi_state_e    state;
        spi_word_t     shift;
        spi_word_t     last_word;       // Read back through data register
        logic [HW-1:0] half_cnt;
        logic [4:0]    bit_cnt;
        logic          half_tick;
        logic          load;

        assign load      = bus.sel && bus.write && (bus.addr[3:0] == REG_DATA)
                           && (state == SPI_IDLE);
        assign half_tick = (half_cnt == HW'(SPI_HALF_PERIOD - 1));
        assign sdata     = shift[23];   // MSB first

        // ------------------------------
        // Shift sequencer
        // ------------------------------
        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        state     <= SPI_IDLE;
                        shift     <= '0;
                        last_word <= '0;
                        half_cnt  <= '0;
                        bit_cnt   <= '0;
                        sclk      <= 1'b0;
                        cs        <= 1'b1;
                        done_irq  <= 1'b0;
                end else begin
                        done_irq <= 1'b0;
                        case (state)
                                SPI_IDLE: if (load) begin
                                        shift     <= bus.wdata[23:0];
                                        last_word <= bus.wdata[23:0];
                                        half_cnt  <= '0;
                                        bit_cnt   <= '0;
                                        cs        <= 1'b0;
                                        state     <= SPI_SHIFT;
                                end
                                SPI_SHIFT: begin
                                        half_cnt <= half_tick ? '0 : half_cnt + 1'b1;
                                        if (half_tick && !sclk) begin
                                                sclk <= 1'b1;           // Rising edge mid-bit
                                        end else if (half_tick) begin
                                                sclk <= 1'b0;           // Data moves on the fall
                                                if (bit_cnt == 5'd23) begin
                                                        cs       <= 1'b1;
                                                        done_irq <= 1'b1;
                                                        state    <= SPI_IDLE;
                                                end else begin
                                                        shift   <= shift << 1;
                                                        bit_cnt <= bit_cnt + 1'b1;
                                                end
                                        end
                                end
                                default: state <= SPI_IDLE;
                        endcase
                end
        end

        // Status bit 0 is busy
        assign bus.rdata = (bus.addr[3:0] == REG_STATUS) ? data_t'(state == SPI_SHIFT)
                                                         : data_t'(last_word);

endmodule

//--- soc_bus_top.sv
module soc_bus_top #(
        parameter int RAM_ADDR_WIDTH  = 12,
        parameter int CLKS_PER_BIT    = 434,
        parameter int SPI_HALF_PERIOD = 4
) (
        input  logic             clk,
        input  logic             RSTn,
        // Bus master side
        input  ahb_pkg::addr_t   haddr,
        input  ahb_pkg::htrans_e htrans,
        input  ahb_pkg::hsize_t  hsize,
        input  logic             hwrite,
        input  ahb_pkg::data_t   hwdata,
        output ahb_pkg::data_t   hrdata,
        // Serial
        input  logic             rxd,
        output logic             txd,
        // Tuner SPI
        output logic             spi_sclk,
        output logic             spi_sdata,
        output logic             spi_cs,
        // Interrupt pulses
        output logic             uart_rx_irq,
        output logic             spi_done_irq
);

        // One link per slave
        ahb_slave_if ram_bus ();
        ahb_slave_if uart_bus ();
        ahb_slave_if spi_bus ();

        // ------------------------------
        // Bus control
        // ------------------------------
        ahb_decoder u_decoder (
                .clk      (clk),
                .RSTn     (RSTn),
                .haddr    (haddr),
                .htrans   (htrans),
                .hsize    (hsize),
                .hwrite   (hwrite),
                .hwdata   (hwdata),
                .hrdata   (hrdata),
                .ram_bus  (ram_bus),
                .uart_bus (uart_bus),
                .spi_bus  (spi_bus)
        );

        // ------------------------------
        // Slaves
        // ------------------------------
        ahb_ram #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) u_ram (
                .clk (clk),
                .bus (ram_bus)
        );

        ahb_uart #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart (
                .clk    (clk),
                .RSTn   (RSTn),
                .bus    (uart_bus),
                .rxd    (rxd),
                .txd    (txd),
                .rx_irq (uart_rx_irq)
        );

        ahb_spi #(.SPI_HALF_PERIOD(SPI_HALF_PERIOD)) u_spi (
                .clk      (clk),
                .RSTn     (RSTn),
                .bus      (spi_bus),
                .sclk     (spi_sclk),
                .sdata    (spi_sdata),
                .cs       (spi_cs),
                .done_irq (spi_done_irq)
        );

endmodule

//--- tb_soc_bus.sv
module tb_soc_bus;
        import ahb_pkg::*;
        import periph_pkg::*;

        localparam int CLKS_PER_BIT    = 16;
        localparam int SPI_HALF_PERIOD = 2;
        localparam int NWORDS          = 8;     // RAM locations under test
        localparam int SPI_FRAME       = 24 * 2 * SPI_HALF_PERIOD;
        // Two UART frames, one SPI frame with margin, plus bus traffic
        localparam int WATCHDOG_CYCLES = 2 * (2 * 10 * CLKS_PER_BIT + SPI_FRAME) + 400;

        logic      clk, RSTn;
        addr_t     haddr;
        htrans_e   htrans;
        hsize_t    hsize;
        logic      hwrite;
        data_t     hwdata, hrdata;
        logic      rxd, txd;
        logic      spi_sclk, spi_sdata, spi_cs;
        logic      uart_rx_irq, spi_done_irq;

        int        errors = 0;
        int        checks = 0;
        int        tests = 0;
        int        test_base = 0;          // Error count when the current test began
        logic [31:0] lfsr = 32'hf5d5_92f9;
        addr_t     ram_addr [NWORDS];
        data_t     ram_exp [NWORDS];        // Shadow of the RAM words
        logic [23:0] spi_shift_in = '0;
        int        sclk_rises = 0;
        int        rx_irq_seen = 0;
        int        spi_irq_seen = 0;

        soc_bus_top #(
                .CLKS_PER_BIT    (CLKS_PER_BIT),
                .SPI_HALF_PERIOD (SPI_HALF_PERIOD)
        ) u_dut (.*);

        initial begin
                clk = 1'b0;
                forever #5 clk = ~clk;
        end

        // ------------------------------
        // Helpers
        // ------------------------------
        // Galois LFSR, one step per bit
        function automatic logic [31:0] next_bits(input int n);
                logic [31:0] r;
                logic        lsb;
                r = '0;
                for (int i = 0; i < n; i++) begin
                        lsb  = lfsr[0];
                        lfsr = lfsr >> 1;
                        if (lsb)
                                lfsr = lfsr ^ 32'h8020_0003;
                        r = {r[30:0], lsb};
                end
                return r;
        endfunction

        task automatic check_eq(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
                checks++;
                assert (got === exp) else begin
                        $display("MISMATCH %s: got 0x%h expected 0x%h", what, got, exp);
                        errors++;
                end
        endtask

        task automatic end_test(input string name);
                tests++;
                $display("test %-16s %s (%0d errors)", name,
                         (errors == test_base) ? "ok" : "failed", errors - test_base);
                test_base = errors;
        endtask

        // One address phase, then one data phase
        task automatic write_bus(input addr_t a, input data_t d, input hsize_t s);
                @(posedge clk);
                haddr  <= a;
                htrans <= NONSEQ;
                hwrite <= 1'b1;
                hsize  <= s;
                @(posedge clk);
                htrans <= IDLE;
                hwdata <= d;            // Commits at the next edge
        endtask

        task automatic read_bus(input addr_t a, output data_t d);
                @(posedge clk);
                haddr  <= a;
                htrans <= NONSEQ;
                hwrite <= 1'b0;
                hsize  <= HSIZE_WORD;
                @(posedge clk);
                htrans <= IDLE;
                @(negedge clk);         // Mid data phase
                d = hrdata;
        endtask

        // ------------------------------
        // Serial models
        // ------------------------------
        task automatic capture_txd(output byte_t b);
                @(negedge txd);
                repeat (CLKS_PER_BIT / 2) @(negedge clk);       // To mid start bit
                check_eq("txd start bit", txd, 0);
                for (int i = 0; i < 8; i++) begin
                        repeat (CLKS_PER_BIT) @(negedge clk);
                        b[i] = txd;     // LSB first
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                check_eq("txd stop bit", txd, 1);
        endtask

        task automatic send_rxd(input byte_t b);
                @(posedge clk);
                rxd <= 1'b0;
                repeat (CLKS_PER_BIT) @(posedge clk);
                for (int i = 0; i < 8; i++) begin
                        rxd <= b[i];
                        repeat (CLKS_PER_BIT) @(posedge clk);
                end
                rxd <= 1'b1;            // Stop bit
                repeat (CLKS_PER_BIT) @(posedge clk);
        endtask

        always @(posedge spi_sclk) begin
                if (!spi_cs) begin
                        spi_shift_in <= {spi_shift_in[22:0], spi_sdata};
                        sclk_rises   <= sclk_rises + 1;
                end
        end

        // Irq cycles counted where the level is stable
        always @(negedge clk) begin
                rx_irq_seen  <= rx_irq_seen + int'(uart_rx_irq);
                spi_irq_seen <= spi_irq_seen + int'(spi_done_irq);
        end

        // ------------------------------
        // Protocol properties
        // ------------------------------
        rx_irq_pulse: assert property (@(posedge clk) disable iff (!RSTn)
                        uart_rx_irq |=> !uart_rx_irq)
                else begin
                        $display("uart_rx_irq stayed high for more than one clock");
                        errors++;
                end
        spi_irq_pulse: assert property (@(posedge clk) disable iff (!RSTn)
                        spi_done_irq |=> !spi_done_irq)
                else begin
                        $display("spi_done_irq stayed high for more than one clock");
                        errors++;
                end
        sclk_idle_low: assert property (@(posedge clk) disable iff (!RSTn)
                        spi_cs |-> !spi_sclk)
                else begin
                        $display("spi_sclk high while spi_cs is deasserted");
                        errors++;
                end
        sdata_hold: assert property (@(posedge clk) disable iff (!RSTn)
                        spi_sclk |-> $stable(spi_sdata))
                else begin
                        $display("spi_sdata changed while spi_sclk was high");
                        errors++;
                end

        initial begin
                repeat (WATCHDOG_CYCLES) @(posedge clk);
                $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
                $display("FAIL: see errors above");
                $finish;
        end

        // ------------------------------
        // Test sequence
        // ------------------------------
        initial begin
                data_t     rd;
                byte_t     tx_byte, tx_got, rx_byte;
                spi_word_t spi_word;
                int        lane, seen0, rises0, irq0;

                RSTn   = 1'b0;
                haddr  = '0;
                htrans = IDLE;
                hsize  = HSIZE_WORD;
                hwrite = 1'b0;
                hwdata = '0;
                rxd    = 1'b1;
                repeat (2) @(posedge clk);
                RSTn <= 1'b1;
                @(negedge clk);

                // Reset state
                check_eq("txd", txd, 1);
                check_eq("spi_cs", spi_cs, 1);
                check_eq("spi_sclk", spi_sclk, 0);
                check_eq("uart_rx_irq", uart_rx_irq, 0);
                check_eq("spi_done_irq", spi_done_irq, 0);
                read_bus(UART_BASE + REG_STATUS, rd);
                check_eq("uart status", rd, 0);
                read_bus(SPI_BASE + REG_STATUS, rd);
                check_eq("spi status", rd, 0);
                end_test("reset");

                // RAM words, word 0 included for the default-slave check
                for (int i = 0; i < NWORDS; i++) begin
                        ram_addr[i] = RAM_BASE
                                + addr_t'((i * 16 + (i == 0 ? 0 : int'(next_bits(4)))) * 4);
                        ram_exp[i]  = next_bits(32);
                        write_bus(ram_addr[i], ram_exp[i], HSIZE_WORD);
                end
                for (int i = 0; i < NWORDS; i++) begin
                        read_bus(ram_addr[i], rd);
                        check_eq("hrdata ram word", rd, ram_exp[i]);
                end
                for (int i = 0; i < NWORDS; i++) begin
                        lane    = int'(next_bits(2));
                        tx_byte = byte_t'(next_bits(8));
                        write_bus(ram_addr[i] + addr_t'(lane), {4{tx_byte}}, HSIZE_BYTE);
                        ram_exp[i][8*lane +: 8] = tx_byte;
                        lane = int'(next_bits(1));
                        rd   = next_bits(16);
                        write_bus(ram_addr[i] + addr_t'(2 * lane), {2{rd[15:0]}}, HSIZE_HALF);
                        ram_exp[i][16*lane +: 16] = rd[15:0];
                end
                for (int i = 0; i < NWORDS; i++) begin
                        read_bus(ram_addr[i], rd);
                        check_eq("hrdata ram lanes", rd, ram_exp[i]);
                end
                end_test("ram");

                // UART transmit, second write lands mid-frame
                tx_byte = byte_t'(next_bits(8));
                write_bus(UART_BASE + REG_DATA, data_t'(tx_byte), HSIZE_WORD);
                fork
                        capture_txd(tx_got);
                        begin
                                read_bus(UART_BASE + REG_STATUS, rd);
                                check_eq("uart status busy", rd, 32'h1);
                                write_bus(UART_BASE + REG_DATA, data_t'(~tx_byte), HSIZE_WORD);
                        end
                join
                check_eq("txd byte", tx_got, tx_byte);
                repeat (CLKS_PER_BIT) @(negedge clk);   // Rest of the stop bit
                read_bus(UART_BASE + REG_STATUS, rd);
                check_eq("uart status idle", rd, 0);
                end_test("uart transmit");

                // UART receive
                rx_byte = byte_t'(next_bits(8));
                seen0   = rx_irq_seen;
                send_rxd(rx_byte);
                for (int n = 0; n < 2 * CLKS_PER_BIT && rx_irq_seen == seen0; n++)
                        @(negedge clk);
                assert (rx_irq_seen != seen0) else begin
                        $display("no uart_rx_irq pulse after a received frame");
                        errors++;
                end
                read_bus(UART_BASE + REG_STATUS, rd);
                check_eq("uart status rx valid", rd, 32'h2);
                read_bus(UART_BASE + REG_DATA, rd);
                check_eq("uart rx data", rd, data_t'(rx_byte));
                read_bus(UART_BASE + REG_STATUS, rd);
                check_eq("uart status cleared", rd, 0);
                check_eq("uart_rx_irq cycles", rx_irq_seen - seen0, 1);
                end_test("uart receive");

                // SPI transmit, write while busy is dropped
                spi_word = spi_word_t'(next_bits(24));
                rises0   = sclk_rises;
                irq0     = spi_irq_seen;
                write_bus(SPI_BASE + REG_DATA, data_t'(spi_word), HSIZE_WORD);
                read_bus(SPI_BASE + REG_STATUS, rd);
                check_eq("spi status busy", rd, 32'h1);
                write_bus(SPI_BASE + REG_DATA, data_t'(~spi_word), HSIZE_WORD);
                for (int n = 0; n < SPI_FRAME + 20 && !spi_cs; n++)
                        @(negedge clk);
                assert (spi_cs) else begin
                        $display("spi_cs did not return high after the frame");
                        errors++;
                end
                read_bus(SPI_BASE + REG_STATUS, rd);
                check_eq("spi status idle", rd, 0);
                read_bus(SPI_BASE + REG_DATA, rd);
                check_eq("spi data readback", rd, data_t'(spi_word));
                check_eq("spi_sdata word", spi_shift_in, spi_word);
                check_eq("spi_sclk rises", sclk_rises - rises0, 24);
                check_eq("spi_done_irq cycles", spi_irq_seen - irq0, 1);
                end_test("spi transmit");

                // Default slave
                read_bus(32'h8000_0000, rd);
                check_eq("hrdata unmapped", rd, 0);
                write_bus(32'h8000_0000, next_bits(32), HSIZE_WORD);
                for (int i = 0; i < NWORDS; i++) begin
                        read_bus(ram_addr[i], rd);
                        check_eq("hrdata ram after unmapped write", rd, ram_exp[i]);
                end
                end_test("default slave");

                $display("tests: %0d  checks: %0d  errors: %0d", tests, checks, errors);
                if (errors == 0)
                        $display("PASS: all tests");
                else
                        $display("FAIL: see errors above");
                $finish;
        end

endmodule

//--- files.f
ahb_pkg.sv
periph_pkg.sv
ahb_slave_if.sv
ahb_decoder.sv
ahb_ram.sv
ahb_uart.sv
ahb_spi.sv
soc_bus_top.sv
tb_soc_bus.sv

//--- Bender.yml
package:
  name: soc_bus

sources:
  - ahb_pkg.sv
  - periph_pkg.sv
  - ahb_slave_if.sv
  - ahb_decoder.sv
  - ahb_ram.sv
  - ahb_uart.sv
  - ahb_spi.sv
  - soc_bus_top.sv
  - target: test
    files:
      - tb_soc_bus.sv
